// File: include/icache_cfg.svh
// --------------------------------------------------
// Instruction cache geometry
// Sizes and widths shared by the lookup pipeline
// --------------------------------------------------

`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Fetch side
`define ICACHE_FETCH_AW 32
`define ICACHE_ID_W 4

// One line is 16 bytes
`define ICACHE_LINE_W 128
`define ICACHE_LINE_ALIGN 4

// Lines per set and the matching index width
`define ICACHE_LINE_COUNT 16
`define ICACHE_COUNT_ALIGN 4

// Associativity
`define ICACHE_SET_COUNT 2
`define ICACHE_SET_ALIGN 1

// Everything above offset and index is tag
`define ICACHE_TAG_W (`ICACHE_FETCH_AW - `ICACHE_LINE_ALIGN - `ICACHE_COUNT_ALIGN)

`endif

// File: hdl/icache_addr_pkg.sv
// --------------------------------------------------
// Instruction cache address types
// Fetch addresses, request IDs and memory indices
// --------------------------------------------------

`include "icache_cfg.svh"

package icache_addr_pkg;

    // Byte address of a fetch request
    typedef logic [`ICACHE_FETCH_AW-1:0] fetch_addr_t;

    // Tag that the requester uses to match responses
    typedef logic [`ICACHE_ID_W-1:0] req_id_t;

    // Line index inside one set
    typedef logic [`ICACHE_COUNT_ALIGN-1:0] line_idx_t;

    // Set number and one-hot set mask
    typedef logic [`ICACHE_SET_ALIGN-1:0] set_idx_t;
    typedef logic [`ICACHE_SET_COUNT-1:0] set_mask_t;

    // Data memory word, set number above the line index
    typedef logic [`ICACHE_SET_ALIGN+`ICACHE_COUNT_ALIGN-1:0] data_addr_t;

endpackage

// File: hdl/icache_line_pkg.sv
// --------------------------------------------------
// Instruction cache line types
// Stored tag entries and line payload
// --------------------------------------------------

`include "icache_cfg.svh"

package icache_line_pkg;

    typedef logic [`ICACHE_TAG_W-1:0] tag_t;

    // Tag entry layout is {valid, error, tag}
    typedef logic [`ICACHE_TAG_W+1:0] tag_entry_t;

    localparam int unsigned ENTRY_W     = `ICACHE_TAG_W + 2;
    localparam int unsigned ENTRY_VALID = `ICACHE_TAG_W + 1;
    localparam int unsigned ENTRY_ERROR = `ICACHE_TAG_W;

    // One full cache line
    typedef logic [`ICACHE_LINE_W-1:0] line_data_t;

endpackage

// File: hdl/icache_sram.sv
// --------------------------------------------------
// Single-port SRAM model
// One-cycle read latency, write enables per lane
// --------------------------------------------------

module icache_sram #(
    parameter int unsigned DATA_W    = 32,
    parameter int unsigned NUM_WORDS = 16,
    parameter int unsigned LANES     = 1
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         req_i,
    input  logic                         we_i,
    input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
    input  logic [DATA_W-1:0]            wdata_i,
    input  logic [LANES-1:0]             be_i,
    output logic [DATA_W-1:0]            rdata_o
);

    localparam int unsigned LANE_W = DATA_W / LANES;

    logic [DATA_W-1:0] mem_q [NUM_WORDS];

    // The read port only updates on a read, so rdata_o holds between reads
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            for (int l = 0; l < LANES; l++) begin
                if (be_i[l]) begin
                    mem_q[addr_i][l*LANE_W +: LANE_W] <= wdata_i[l*LANE_W +: LANE_W];
                end
            end
        end
        if (req_i && !we_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

    addr_in_range_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        req_i |-> (addr_i < NUM_WORDS)
    );

endmodule

// File: hdl/icache_init_ctrl.sv
// --------------------------------------------------
// Init and flush controller
// Walks every line index to clear the tag memory
// --------------------------------------------------

`include "icache_cfg.svh"

module icache_init_ctrl
    import icache_addr_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_valid_i,
    output logic      init_busy_o,
    output line_idx_t init_idx_o
);

    localparam logic [`ICACHE_COUNT_ALIGN:0] LINES =
        (`ICACHE_COUNT_ALIGN+1)'(`ICACHE_LINE_COUNT);

    // One extra bit so the counter can rest at LINE_COUNT when done
    logic [`ICACHE_COUNT_ALIGN:0] count_q;

    assign init_busy_o = (count_q != LINES);
    assign init_idx_o  = count_q[`ICACHE_COUNT_ALIGN-1:0];

    // A flush is ignored while a walk is still running
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (init_busy_o) begin
            count_q <= count_q + 1'b1;
        end else if (flush_valid_i) begin
            count_q <= '0;
        end
    end

    // Flush is a single-cycle strobe
    flush_strobe_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        flush_valid_i |=> !flush_valid_i
    );

endmodule

// File: hdl/icache_tag_stage.sv
// --------------------------------------------------
// Lookup tag stage
// Tag port arbitration, tag compare and the tag buffer
// --------------------------------------------------

`include "icache_cfg.svh"

module icache_tag_stage
    import icache_addr_pkg::*;
    import icache_line_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        init_busy_i,
    input  line_idx_t   init_idx_i,
    input  fetch_addr_t in_addr_i,
    input  req_id_t     in_id_i,
    input  logic        in_valid_i,
    output logic        in_ready_o,
    input  line_idx_t   write_addr_i,
    input  set_idx_t    write_set_i,
    input  tag_t        write_tag_i,
    input  logic        write_error_i,
    input  logic        write_valid_i,
    output logic        write_ready_o,
    output logic        tag_valid_o,
    output fetch_addr_t tag_addr_o,
    output req_id_t     tag_id_o,
    output set_idx_t    tag_set_o,
    output logic        tag_hit_o,
    output logic        tag_error_o,
    input  logic        tag_ready_i
);

    localparam int unsigned TAG_MEM_W = `ICACHE_SET_COUNT * ENTRY_W;

    line_idx_t  mem_idx;
    set_mask_t  mem_be;
    logic       mem_we;
    tag_entry_t mem_wentry;
    logic [TAG_MEM_W-1:0] mem_rdata;

    logic        accept;
    logic        rd_pending_q;
    logic        tag_valid_q;
    fetch_addr_t addr_q;
    req_id_t     id_q;

    // --------------------------------------------------
    // Port arbitration
    // --------------------------------------------------

    assign write_ready_o = !init_busy_i;
    assign in_ready_o    = !init_busy_i && !write_valid_i && (!tag_valid_q || tag_ready_i);
    assign accept        = in_valid_i && in_ready_o;

    // Init beats refill, refill beats lookup
    always_comb begin
        mem_idx    = in_addr_i[`ICACHE_LINE_ALIGN +: `ICACHE_COUNT_ALIGN];
        mem_be     = '1;
        mem_we     = 1'b0;
        mem_wentry = {1'b1, write_error_i, write_tag_i};
        if (init_busy_i) begin
            mem_idx    = init_idx_i;
            mem_we     = 1'b1;
            mem_wentry = '0;
        end else if (write_valid_i) begin
            mem_idx = write_addr_i;
            mem_be  = set_mask_t'(1) << write_set_i;
            mem_we  = 1'b1;
        end
    end

    // All sets of one index share a word, one lane each
    icache_sram #(
        .DATA_W    (TAG_MEM_W),
        .NUM_WORDS (`ICACHE_LINE_COUNT),
        .LANES     (`ICACHE_SET_COUNT)
    ) i_tag_sram (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (mem_we || accept),
        .we_i    (mem_we),
        .addr_i  (mem_idx),
        .wdata_i ({`ICACHE_SET_COUNT{mem_wentry}}),
        .be_i    (mem_be),
        .rdata_o (mem_rdata)
    );

    // --------------------------------------------------
    // Request register
    // --------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= in_addr_i;
            id_q   <= in_id_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tag_valid_q  <= 1'b0;
            rd_pending_q <= 1'b0;
        end else begin
            tag_valid_q  <= accept ? 1'b1 : (tag_ready_i ? 1'b0 : tag_valid_q);
            rd_pending_q <= accept;
        end
    end

    // --------------------------------------------------
    // Hit detection
    // --------------------------------------------------

    tag_t       req_tag;
    tag_entry_t rd_entry [`ICACHE_SET_COUNT];
    set_mask_t  hit_mask;
    set_idx_t   set_s, set_q, set_d;
    logic       hit_s, hit_q, hit_d;
    logic       err_s, err_q, err_d;

    assign req_tag = addr_q[`ICACHE_FETCH_AW-1 -: `ICACHE_TAG_W];

    for (genvar s = 0; s < `ICACHE_SET_COUNT; s++) begin : g_cmp
        assign rd_entry[s] = mem_rdata[s*ENTRY_W +: ENTRY_W];
        assign hit_mask[s] = rd_entry[s][ENTRY_VALID] &&
                             (rd_entry[s][`ICACHE_TAG_W-1:0] == req_tag);
    end

    // Walk downwards so that the lowest hitting set wins
    always_comb begin
        set_s = '0;
        hit_s = |hit_mask;
        err_s = 1'b0;
        for (int s = `ICACHE_SET_COUNT - 1; s >= 0; s--) begin
            if (hit_mask[s]) begin
                set_s = set_idx_t'(s);
                err_s = rd_entry[s][ENTRY_ERROR];
            end
        end
    end

    // --------------------------------------------------
    // Fall-through buffer
    // --------------------------------------------------

    // The SRAM output is only valid in the cycle after the read
    assign tag_set_o   = rd_pending_q ? set_s : set_q;
    assign tag_hit_o   = rd_pending_q ? hit_s : hit_q;
    assign tag_error_o = rd_pending_q ? err_s : err_q;
    assign tag_valid_o = tag_valid_q;
    assign tag_addr_o  = addr_q;
    assign tag_id_o    = id_q;

    always_comb begin
        set_d = set_q;
        hit_d = hit_q;
        err_d = err_q;
        if (rd_pending_q && !tag_ready_i) begin
            set_d = set_s;
            hit_d = hit_s;
            err_d = err_s;
        end
        // A refill into the waiting line makes the hit stale
        if (write_valid_i && write_ready_o && (write_set_i == tag_set_o) &&
            (write_addr_i == addr_q[`ICACHE_LINE_ALIGN +: `ICACHE_COUNT_ALIGN])) begin
            hit_d = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        set_q <= set_d;
        hit_q <= hit_d;
        err_q <= err_d;
    end

    one_set_hits_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        rd_pending_q |-> $onehot0(hit_mask)
    );

endmodule

// File: hdl/icache_data_stage.sv
// --------------------------------------------------
// Lookup data stage
// Data port arbitration, line read and output buffer
// --------------------------------------------------

`include "icache_cfg.svh"

module icache_data_stage
    import icache_addr_pkg::*;
    import icache_line_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        init_busy_i,
    input  logic        tag_valid_i,
    output logic        tag_ready_o,
    input  fetch_addr_t tag_addr_i,
    input  req_id_t     tag_id_i,
    input  set_idx_t    tag_set_i,
    input  logic        tag_hit_i,
    input  logic        tag_error_i,
    input  line_idx_t   write_addr_i,
    input  set_idx_t    write_set_i,
    input  line_data_t  write_data_i,
    input  logic        write_valid_i,
    output fetch_addr_t out_addr_o,
    output req_id_t     out_id_o,
    output set_idx_t    out_set_o,
    output logic        out_hit_o,
    output logic        out_error_o,
    output line_data_t  out_data_o,
    output logic        out_valid_o,
    input  logic        out_ready_i
);

    logic       data_we;
    logic       rd_en;
    logic       tag_xfer;
    data_addr_t mem_addr;
    line_data_t mem_rdata;

    logic       out_valid_q;
    logic       rd_pending_q;
    line_data_t line_q;

    // --------------------------------------------------
    // Port arbitration
    // --------------------------------------------------

    // Refills own the port, lookups wait a cycle
    assign data_we     = write_valid_i && !init_busy_i;
    assign tag_ready_o = (!out_valid_q || out_ready_i) && !data_we;
    assign tag_xfer    = tag_valid_i && tag_ready_o;

    // Misses never touch the data memory
    assign rd_en    = tag_xfer && tag_hit_i;
    assign mem_addr = data_we ? {write_set_i, write_addr_i}
                              : {tag_set_i, tag_addr_i[`ICACHE_LINE_ALIGN +: `ICACHE_COUNT_ALIGN]};

    icache_sram #(
        .DATA_W    (`ICACHE_LINE_W),
        .NUM_WORDS (`ICACHE_LINE_COUNT * `ICACHE_SET_COUNT),
        .LANES     (1)
    ) i_data_sram (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (data_we || rd_en),
        .we_i    (data_we),
        .addr_i  (mem_addr),
        .wdata_i (write_data_i),
        .be_i    (1'b1),
        .rdata_o (mem_rdata)
    );

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (tag_xfer) begin
            out_addr_o  <= tag_addr_i;
            out_id_o    <= tag_id_i;
            out_set_o   <= tag_set_i;
            out_hit_o   <= tag_hit_i;
            out_error_o <= tag_error_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            out_valid_q  <= 1'b0;
            rd_pending_q <= 1'b0;
        end else begin
            out_valid_q  <= tag_xfer ? 1'b1 : (out_ready_i ? 1'b0 : out_valid_q);
            rd_pending_q <= rd_en;
        end
    end

    // Keep the read line when the consumer stalls on it
    always_ff @(posedge clk_i) begin
        if (rd_pending_q && !out_ready_i) begin
            line_q <= mem_rdata;
        end
    end

    assign out_data_o  = rd_pending_q ? mem_rdata : line_q;
    assign out_valid_o = out_valid_q;

    out_hold_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        out_valid_o && !out_ready_i |=>
            out_valid_o &&
            $stable({out_addr_o, out_id_o, out_set_o, out_hit_o, out_error_o}) &&
            (!out_hit_o || $stable(out_data_o))
    );

endmodule

// File: hdl/icache_lookup.sv
// --------------------------------------------------
// Instruction cache lookup pipeline
// Init controller, tag stage and data stage
// --------------------------------------------------

module icache_lookup
    import icache_addr_pkg::*;
    import icache_line_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        flush_valid_i,
    input  fetch_addr_t in_addr_i,
    input  req_id_t     in_id_i,
    input  logic        in_valid_i,
    output logic        in_ready_o,
    output fetch_addr_t out_addr_o,
    output req_id_t     out_id_o,
    output set_idx_t    out_set_o,
    output logic        out_hit_o,
    output logic        out_error_o,
    output line_data_t  out_data_o,
    output logic        out_valid_o,
    input  logic        out_ready_i,
    input  line_idx_t   write_addr_i,
    input  set_idx_t    write_set_i,
    input  line_data_t  write_data_i,
    input  tag_t        write_tag_i,
    input  logic        write_error_i,
    input  logic        write_valid_i,
    output logic        write_ready_o
);

    logic        init_busy;
    line_idx_t   init_idx;

    // Tag stage to data stage
    logic        tag_valid;
    logic        tag_ready;
    fetch_addr_t tag_addr;
    req_id_t     tag_id;
    set_idx_t    tag_set;
    logic        tag_hit;
    logic        tag_error;

    icache_init_ctrl i_init_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_valid_i (flush_valid_i),
        .init_busy_o   (init_busy),
        .init_idx_o    (init_idx)
    );

    icache_tag_stage i_tag_stage (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .init_busy_i   (init_busy),
        .init_idx_i    (init_idx),
        .in_addr_i     (in_addr_i),
        .in_id_i       (in_id_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .write_addr_i  (write_addr_i),
        .write_set_i   (write_set_i),
        .write_tag_i   (write_tag_i),
        .write_error_i (write_error_i),
        .write_valid_i (write_valid_i),
        .write_ready_o (write_ready_o),
        .tag_valid_o   (tag_valid),
        .tag_addr_o    (tag_addr),
        .tag_id_o      (tag_id),
        .tag_set_o     (tag_set),
        .tag_hit_o     (tag_hit),
        .tag_error_o   (tag_error),
        .tag_ready_i   (tag_ready)
    );

    icache_data_stage i_data_stage (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .init_busy_i   (init_busy),
        .tag_valid_i   (tag_valid),
        .tag_ready_o   (tag_ready),
        .tag_addr_i    (tag_addr),
        .tag_id_i      (tag_id),
        .tag_set_i     (tag_set),
        .tag_hit_i     (tag_hit),
        .tag_error_i   (tag_error),
        .write_addr_i  (write_addr_i),
        .write_set_i   (write_set_i),
        .write_data_i  (write_data_i),
        .write_valid_i (write_valid_i),
        .out_addr_o    (out_addr_o),
        .out_id_o      (out_id_o),
        .out_set_o     (out_set_o),
        .out_hit_o     (out_hit_o),
        .out_error_o   (out_error_o),
        .out_data_o    (out_data_o),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i)
    );

endmodule

// File: bench/tb_icache_lookup.sv
// --------------------------------------------------
// Testbench for the instruction cache lookup
// Table of refills, lookups and flushes with a shadow model
// --------------------------------------------------

`include "icache_cfg.svh"

module tb_icache_lookup
    import icache_addr_pkg::*;
    import icache_line_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int SAMPLE_DELAY = CLK_PERIOD / 4;
    localparam int NUM_STEPS    = 34;
    localparam int INIT_CYCLES  = 5 + `ICACHE_LINE_COUNT;
    localparam int STALL_LIMIT  = 100;
    localparam int META_W       = `ICACHE_FETCH_AW + `ICACHE_ID_W + `ICACHE_SET_ALIGN + 2;

    localparam int OP_IDLE   = 0;
    localparam int OP_REFILL = 1;
    localparam int OP_LOOKUP = 2;
    localparam int OP_FLUSH  = 3;

    localparam tag_t TAG_A = 24'h1a_2b3c;
    localparam tag_t TAG_B = 24'h00_0b17;
    localparam tag_t TAG_C = 24'hc0_ffee;
    localparam tag_t TAG_D = 24'h7e_5a01;
    localparam tag_t TAG_E = 24'hff_0042;

    typedef struct packed {
        logic [1:0] op;
        line_idx_t  idx;
        set_idx_t   set;
        tag_t       tag;
        logic       err;
        logic       bp;
        logic       hit;
        set_idx_t   hit_set;
        logic       hit_err;
    } step_t;

    typedef struct packed {
        fetch_addr_t addr;
        req_id_t     id;
        logic        hit;
        set_idx_t    set;
        logic        err;
        line_data_t  data;
        logic        timed;
        logic [31:0] acc_cyc;
    } resp_t;

    logic        clk_i;
    logic        rst_ni;
    logic        flush_valid_i;
    fetch_addr_t in_addr_i;
    req_id_t     in_id_i;
    logic        in_valid_i;
    logic        in_ready_o;
    fetch_addr_t out_addr_o;
    req_id_t     out_id_o;
    set_idx_t    out_set_o;
    logic        out_hit_o;
    logic        out_error_o;
    line_data_t  out_data_o;
    logic        out_valid_o;
    logic        out_ready_i;
    line_idx_t   write_addr_i;
    set_idx_t    write_set_i;
    line_data_t  write_data_i;
    tag_t        write_tag_i;
    logic        write_error_i;
    logic        write_valid_i;
    logic        write_ready_o;

    step_t       steps [NUM_STEPS];
    int          n_steps;
    step_t       cur;
    resp_t       exp_q [$];
    line_data_t  shadow [`ICACHE_SET_COUNT * `ICACHE_LINE_COUNT];
    integer      seed = 32'h3ade_a609;
    int          cyc = 0;
    logic        bp_mode;
    req_id_t     next_id;
    fetch_addr_t lk_addr;
    req_id_t     lk_id;
    logic        accepted;
    logic        wrote;
    logic        hold_q;
    logic        prev_hit;
    logic [META_W-1:0] prev_meta;
    line_data_t  prev_data;

    icache_lookup i_dut (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_valid_i (flush_valid_i),
        .in_addr_i     (in_addr_i),
        .in_id_i       (in_id_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .out_addr_o    (out_addr_o),
        .out_id_o      (out_id_o),
        .out_set_o     (out_set_o),
        .out_hit_o     (out_hit_o),
        .out_error_o   (out_error_o),
        .out_data_o    (out_data_o),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .write_addr_i  (write_addr_i),
        .write_set_i   (write_set_i),
        .write_data_i  (write_data_i),
        .write_tag_i   (write_tag_i),
        .write_error_i (write_error_i),
        .write_valid_i (write_valid_i),
        .write_ready_o (write_ready_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) cyc <= cyc + 1;

    // --------------------------------------------------
    // Failure reporting and checks
    // --------------------------------------------------

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic fail_plain(input string what);
        $display("Failure: %s", what);
        abort_run();
    endtask

    task automatic check_val(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s exp %h act %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic add_step(input int op, input int idx, input int set, input tag_t tag,
                            input int err, input int bp, input int hit, input int hit_set,
                            input int hit_err);
        steps[n_steps].op      = 2'(op);
        steps[n_steps].idx     = line_idx_t'(idx);
        steps[n_steps].set     = set_idx_t'(set);
        steps[n_steps].tag     = tag;
        steps[n_steps].err     = err[0];
        steps[n_steps].bp      = bp[0];
        steps[n_steps].hit     = hit[0];
        steps[n_steps].hit_set = set_idx_t'(hit_set);
        steps[n_steps].hit_err = hit_err[0];
        n_steps++;
    endtask

    // --------------------------------------------------
    // Cycle handling
    // --------------------------------------------------

    // Inputs change on the falling edge and every valid defaults to low
    task automatic begin_cycle();
        @(negedge clk_i);
        in_valid_i    = 1'b0;
        write_valid_i = 1'b0;
        flush_valid_i = 1'b0;
        out_ready_i   = bp_mode ? 1'($random(seed)) : 1'b1;
    endtask

    // Everything is settled a quarter period after the falling edge
    task automatic end_cycle();
        #(SAMPLE_DELAY);
        sample_cycle();
    endtask

    task automatic sample_cycle();
        resp_t             e;
        logic [META_W-1:0] meta;
        meta = {out_addr_o, out_id_o, out_set_o, out_hit_o, out_error_o};
        if (hold_q) begin
            check_val("out_valid_o", 1'b1, out_valid_o);
            check_val("held outputs", prev_meta, meta);
            if (prev_hit) begin
                check_val("held out_data_o", prev_data, out_data_o);
            end
        end
        hold_q    = out_valid_o && !out_ready_i;
        prev_meta = meta;
        prev_hit  = out_hit_o;
        prev_data = out_data_o;
        if (out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                fail_plain("a response arrived with no lookup outstanding");
            end else begin
                e = exp_q.pop_front();
                check_val("out_addr_o", e.addr, out_addr_o);
                check_val("out_id_o", e.id, out_id_o);
                check_val("out_hit_o", e.hit, out_hit_o);
                check_val("out_error_o", e.err, out_error_o);
                if (e.hit) begin
                    check_val("out_set_o", e.set, out_set_o);
                    check_val("out_data_o", e.data, out_data_o);
                end
                if (e.timed) begin
                    check_val("response latency", 2, cyc - e.acc_cyc);
                end
            end
        end
        accepted = in_valid_i && in_ready_o;
        if (accepted) begin
            e.addr    = lk_addr;
            e.id      = lk_id;
            e.hit     = cur.hit;
            e.set     = cur.hit_set;
            e.err     = cur.hit_err;
            e.data    = shadow[data_addr_t'({cur.hit_set, cur.idx})];
            e.timed   = !cur.bp;
            e.acc_cyc = cyc;
            exp_q.push_back(e);
        end
        wrote = write_valid_i && write_ready_o;
        if (wrote) begin
            shadow[data_addr_t'({write_set_i, write_addr_i})] = write_data_i;
        end
    endtask

    // --------------------------------------------------
    // Operations
    // --------------------------------------------------

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            begin_cycle();
            end_cycle();
            waited++;
            if (waited > STALL_LIMIT) begin
                fail_plain("pending lookups were not returned within 100 cycles");
            end
        end
    endtask

    task automatic do_refill();
        line_data_t line;
        int         waited;
        line   = {$random(seed), $random(seed), $random(seed), $random(seed)};
        waited = 0;
        do begin
            begin_cycle();
            write_addr_i  = cur.idx;
            write_set_i   = cur.set;
            write_tag_i   = cur.tag;
            write_error_i = cur.err;
            write_data_i  = line;
            write_valid_i = 1'b1;
            end_cycle();
            waited++;
            if (!wrote && waited > STALL_LIMIT) begin
                fail_plain("a refill was not accepted within 100 cycles");
            end
        end while (!wrote);
    endtask

    task automatic do_lookup();
        int waited;
        // The byte offset changes from request to request
        lk_addr = {cur.tag, cur.idx, ~next_id};
        lk_id   = next_id;
        next_id = next_id + 1'b1;
        waited  = 0;
        do begin
            begin_cycle();
            in_addr_i  = lk_addr;
            in_id_i    = lk_id;
            in_valid_i = 1'b1;
            end_cycle();
            waited++;
            if (!accepted && waited > STALL_LIMIT) begin
                fail_plain("in_ready_o stayed low for more than 100 cycles");
            end
        end while (!accepted);
        if (!cur.bp) begin
            drain();
        end
    endtask

    // Caller has already opened the first cycle of the walk
    task automatic measure_walk(input string name);
        int busy;
        busy = 0;
        end_cycle();
        while (!write_ready_o && busy <= STALL_LIMIT) begin
            check_val("in_ready_o", 1'b0, in_ready_o);
            check_val("out_valid_o", 1'b0, out_valid_o);
            busy++;
            begin_cycle();
            end_cycle();
        end
        check_val(name, `ICACHE_LINE_COUNT, busy);
        check_val("in_ready_o", 1'b1, in_ready_o);
    endtask

    task automatic do_flush();
        begin_cycle();
        flush_valid_i = 1'b1;
        end_cycle();
        check_val("write_ready_o", 1'b1, write_ready_o);
        begin_cycle();
        measure_walk("flush walk cycles");
    endtask

    task automatic fill_table();
        // op, index, set, tag, error, random out_ready, exp hit, exp set, exp error
        add_step(OP_LOOKUP,  3, 0, TAG_A, 0, 0, 0, 0, 0);
        add_step(OP_LOOKUP,  9, 0, TAG_B, 0, 0, 0, 0, 0);
        add_step(OP_REFILL,  3, 0, TAG_A, 0, 0, 0, 0, 0);
        add_step(OP_LOOKUP,  3, 0, TAG_A, 0, 0, 1, 0, 0);
        add_step(OP_REFILL,  5, 0, TAG_C, 0, 0, 0, 0, 0);
        add_step(OP_REFILL,  5, 1, TAG_D, 0, 0, 0, 0, 0);
        add_step(OP_LOOKUP,  5, 0, TAG_C, 0, 0, 1, 0, 0);
        add_step(OP_LOOKUP,  5, 0, TAG_D, 0, 0, 1, 1, 0);
        add_step(OP_LOOKUP,  5, 0, TAG_E, 0, 0, 0, 0, 0);
        add_step(OP_REFILL,  7, 1, TAG_E, 1, 0, 0, 0, 0);
        add_step(OP_LOOKUP,  7, 0, TAG_E, 0, 0, 1, 1, 1);
        add_step(OP_LOOKUP,  7, 0, TAG_A, 0, 0, 0, 0, 0);
        add_step(OP_FLUSH,   0, 0, TAG_A, 0, 0, 0, 0, 0);
        add_step(OP_LOOKUP,  3, 0, TAG_A, 0, 0, 0, 0, 0);
        add_step(OP_LOOKUP,  5, 0, TAG_D, 0, 0, 0, 0, 0);
        add_step(OP_LOOKUP,  7, 0, TAG_E, 0, 0, 0, 0, 0);
        add_step(OP_REFILL,  2, 0, TAG_B, 0, 0, 0, 0, 0);
        add_step(OP_REFILL,  2, 1, TAG_C, 0, 0, 0, 0, 0);
        add_step(OP_REFILL, 11, 1, TAG_D, 1, 0, 0, 0, 0);
        // Burst under back-pressure where refills only touch indices 6 and 13
        add_step(OP_LOOKUP,  2, 0, TAG_B, 0, 1, 1, 0, 0);
        add_step(OP_REFILL,  6, 0, TAG_A, 0, 1, 0, 0, 0);
        add_step(OP_LOOKUP,  2, 0, TAG_C, 0, 1, 1, 1, 0);
        add_step(OP_LOOKUP, 11, 0, TAG_D, 0, 1, 1, 1, 1);
        add_step(OP_REFILL, 13, 1, TAG_E, 0, 1, 0, 0, 0);
        add_step(OP_LOOKUP,  2, 0, TAG_D, 0, 1, 0, 0, 0);
        add_step(OP_LOOKUP, 11, 0, TAG_D, 0, 1, 1, 1, 1);
        add_step(OP_LOOKUP,  2, 0, TAG_B, 0, 1, 1, 0, 0);
        add_step(OP_REFILL,  6, 1, TAG_B, 0, 1, 0, 0, 0);
        add_step(OP_LOOKUP, 11, 0, TAG_A, 0, 1, 0, 0, 0);
        add_step(OP_IDLE,    0, 0, TAG_A, 0, 1, 0, 0, 0);
        add_step(OP_LOOKUP,  6, 0, TAG_A, 0, 0, 1, 0, 0);
        add_step(OP_LOOKUP, 13, 0, TAG_E, 0, 0, 1, 1, 0);
        add_step(OP_LOOKUP,  6, 0, TAG_B, 0, 0, 1, 1, 0);
        add_step(OP_IDLE,    0, 0, TAG_A, 0, 0, 0, 0, 0);
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------

    initial begin
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        flush_valid_i = 1'b0;
        in_addr_i     = '0;
        in_id_i       = '0;
        in_valid_i    = 1'b0;
        out_ready_i   = 1'b1;
        write_addr_i  = '0;
        write_set_i   = '0;
        write_data_i  = '0;
        write_tag_i   = '0;
        write_error_i = 1'b0;
        write_valid_i = 1'b0;
        bp_mode       = 1'b0;
        hold_q        = 1'b0;
        next_id       = '0;
        n_steps       = 0;
        fill_table();

        // Five rising edges with reset low and the release on a falling edge
        repeat (4) @(negedge clk_i);
        begin_cycle();
        rst_ni = 1'b1;
        measure_walk("init walk cycles");

        for (int i = 0; i < n_steps; i++) begin
            cur     = steps[i];
            bp_mode = cur.bp;
            case (cur.op)
                OP_REFILL: do_refill();
                OP_LOOKUP: do_lookup();
                OP_FLUSH:  do_flush();
                default:   drain();
            endcase
        end
        drain();

        if (exp_q.size() != 0) begin
            fail_plain("lookups were still outstanding at the end of the table");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    initial begin
        #((NUM_STEPS * 40 + INIT_CYCLES) * CLK_PERIOD);
        fail_plain("the watchdog expired before the table was finished");
    end

endmodule

// File: build.f
+incdir+include
hdl/icache_addr_pkg.sv
hdl/icache_line_pkg.sv
hdl/icache_sram.sv
hdl/icache_init_ctrl.sv
hdl/icache_tag_stage.sv
hdl/icache_data_stage.sv
hdl/icache_lookup.sv
bench/tb_icache_lookup.sv

// File: Bender.yml
package:
  name: icache_lookup

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/icache_addr_pkg.sv
      - hdl/icache_line_pkg.sv
      - hdl/icache_sram.sv
      - hdl/icache_init_ctrl.sv
      - hdl/icache_tag_stage.sv
      - hdl/icache_data_stage.sv
      - hdl/icache_lookup.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_icache_lookup.sv
